//--- all.f
+incdir+source
source/dqla_pkg.sv
source/quad_encoder.sv
source/motor_cmd_regs.sv
source/dac_chain_ctrl.sv
source/dqla_readback.sv
source/dqla_top.sv
tests/dqla_tb.sv

//--- run.sh
#!/bin/sh
# Build the DQLA testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module dqla_tb \
    -o dqla_sim

output=$(./obj_dir/dqla_sim)
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
else
    exit 1
fi

//--- tests/dqla_tb.sv
// DQLA testbench with clock and reset, encoder and bus stimulus, DAC chain monitor and checks
`timescale 1ns/1ns
`include "dqla_settings.svh"

module dqla_tb;

    localparam int WAIT_LIMIT = 2000;   // sysclk cycles per wait loop

    logic        sysclk;
    logic        arst_n;
    logic [15:0] reg_raddr;
    logic [31:0] reg_rdata;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic        blk_wen;
    logic [7:0]  enc_a;
    logic [7:0]  enc_b;
    logic        dac_sclk;
    logic [1:0]  dac_mosi;
    logic [1:0]  dac_cs_n;
    logic [31:0] timestamp;

    int          checks;
    int          mismatches;
    int          other_errors;
    int          updates;           // Rising edges of the DAC busy flag
    logic        busy_q;
    logic [15:0] cmd_model [8];     // Commands the host has written
    logic [31:0] cnt_model [8];     // Expected encoder positions
    int          gray_pos [8];      // Gray state 0..3 per axis
    logic [23:0] exp_q1 [$];        // Expected frames, chain 1
    logic [23:0] exp_q2 [$];        // Expected frames, chain 2
    logic [23:0] mon_sh [2];
    int          mon_bits [2];

    dqla_top i_dqla_top (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .dac_sclk  (dac_sclk),
        .dac_mosi  (dac_mosi),
        .dac_cs_n  (dac_cs_n),
        .timestamp (timestamp)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;   // 10 ns period
    end

    // --------------------------------------------------
    // Reference model and helpers
    // --------------------------------------------------
    // Frame for axis 1..8 from command, DAC address within the chain and current
    function automatic logic [23:0] dac_frame(input int axis, input logic [15:0] cmd);
        logic [3:0] addr;
        addr = 4'((axis - 1) % 4);
        return {`DQLA_DAC_CMD, addr, cmd};
    endfunction

    function automatic logic [15:0] reg_addr(input int chan, input logic [3:0] off);
        return {`DQLA_ADDR_MAIN, 4'h0, 4'(chan), off};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Next rising edge plus the 1 ns drive delay
    task automatic tick();
        @(posedge sysclk);
        #1;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data,
                             input logic blk);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        blk_wen   = blk;
        tick();
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        reg_raddr = addr;
        tick();                         // One cycle read latency
        data = reg_rdata;
    endtask

    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        while (i_dqla_top.dac_busy !== level && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (i_dqla_top.dac_busy !== level) begin
            other_errors++;
            $display("Timeout at %0t ns while waiting for %s", $time, what);
        end
    endtask

    task automatic wait_frames();
        int n;
        n = 0;
        while ((exp_q1.size() != 0 || exp_q2.size() != 0) && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (exp_q1.size() != 0 || exp_q2.size() != 0) begin
            other_errors++;
            $display("Timeout at %0t ns, %0d DAC frames never arrived", $time,
                     exp_q1.size() + exp_q2.size());
        end
    endtask

    // Snapshot of all commands as one update's frames
    task automatic push_expected();
        for (int i = 1; i <= 4; i++) begin
            exp_q1.push_back(dac_frame(i, cmd_model[i - 1]));
            exp_q2.push_back(dac_frame(i + 4, cmd_model[i + 3]));
        end
    endtask

    // Gray sequence 00, 10, 11, 01 counts up as a leads b
    task automatic encoder_steps(input int n);
        int dir;
        for (int s = 0; s < n; s++) begin
            for (int k = 0; k < 8; k++) begin
                dir = int'($urandom % 3);          // 0 hold, 1 up, 2 down
                if (dir == 1) begin
                    gray_pos[k] = (gray_pos[k] + 1) % 4;
                    cnt_model[k] = cnt_model[k] + 32'd1;
                end else if (dir == 2) begin
                    gray_pos[k] = (gray_pos[k] + 3) % 4;
                    cnt_model[k] = cnt_model[k] - 32'd1;
                end
                enc_a[k] = (gray_pos[k] == 1) || (gray_pos[k] == 2);
                enc_b[k] = (gray_pos[k] >= 2);
            end
            repeat (4) tick();                     // Slow enough for the synchronisers
        end
    endtask

    task automatic check_counts();
        logic [31:0] rd;
        repeat (5) tick();
        for (int k = 0; k < 8; k++) begin
            read_reg(reg_addr(k + 1, `DQLA_OFF_ENC_DATA), rd);
            check_value($sformatf("enc_count axis %0d", k + 1), rd, cnt_model[k]);
        end
    endtask

    // Eight DAC writes and then the block strobe at a DAC offset
    task automatic write_block();
        for (int k = 0; k < 8; k++) begin
            cmd_model[k] = 16'($urandom);
            write_reg(reg_addr(k + 1, `DQLA_OFF_DAC_CTRL), {16'h0, cmd_model[k]}, 1'b0);
        end
        reg_waddr = reg_addr(1, `DQLA_OFF_DAC_CTRL);
        blk_wen   = 1'b1;
        tick();
        blk_wen   = 1'b0;
    endtask

    task automatic single_update(input int axis, input logic [15:0] val);
        write_reg(reg_addr(axis, `DQLA_OFF_DAC_CTRL), {1'b1, 15'h0, val}, 1'b1);
        cmd_model[axis - 1] = val;
        push_expected();
        wait_busy(1'b1, "single update start");
        wait_busy(1'b0, "single update end");
        wait_frames();
    endtask

    // --------------------------------------------------
    // DAC chain monitor and update counter
    // --------------------------------------------------
    task automatic take_frame(input int c, input logic [23:0] frame);
        logic [23:0] exp;
        if ((c == 0 && exp_q1.size() == 0) || (c == 1 && exp_q2.size() == 0)) begin
            other_errors++;
            $display("Unexpected DAC frame %h on chain %0d at %0t ns", frame, c + 1, $time);
        end else begin
            exp = (c == 0) ? exp_q1.pop_front() : exp_q2.pop_front();
            check_value($sformatf("dac_frame chain %0d", c + 1), 32'(frame), 32'(exp));
        end
    endtask

    initial begin
        mon_bits[0] = 0;
        mon_bits[1] = 0;
        forever begin
            @(posedge dac_sclk);                   // Data sampled on rising sclk
            for (int c = 0; c < 2; c++) begin
                if (dac_cs_n[c] == 1'b0) begin
                    mon_sh[c] = {mon_sh[c][22:0], dac_mosi[c]};
                    mon_bits[c]++;
                    if (mon_bits[c] == `DQLA_DAC_FRAME_BITS) begin
                        mon_bits[c] = 0;
                        take_frame(c, mon_sh[c]);
                    end
                end
            end
        end
    end

    always @(posedge sysclk) begin
        busy_q <= i_dqla_top.dac_busy;
        if (i_dqla_top.dac_busy && !busy_q)
            updates++;
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] t1;
        int          base;
        int          k_wait;
        void'($urandom(32'h8326b9e1));
        checks = 0;
        mismatches = 0;
        other_errors = 0;
        updates = 0;
        busy_q = 1'b0;
        arst_n = 1'b0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen = 1'b0;
        blk_wen = 1'b0;
        enc_a = '0;
        enc_b = '0;
        for (int k = 0; k < 8; k++) begin
            cmd_model[k] = '0;
            cnt_model[k] = '0;
            gray_pos[k] = 0;
        end
        repeat (2) @(posedge sysclk);
        #1 arst_n = 1'b1;

        // Reset state
        check_value("dac_cs_n", 32'(dac_cs_n), 32'h3);
        check_value("dac_sclk", 32'(dac_sclk), 32'h0);
        check_value("timestamp", timestamp, 32'h0);
        for (int k = 1; k <= 8; k++) begin
            read_reg(reg_addr(k, `DQLA_OFF_ENC_DATA), rd);
            check_value($sformatf("enc_count axis %0d", k), rd, 32'h0);
            read_reg(reg_addr(k, `DQLA_OFF_DAC_CTRL), rd);
            check_value($sformatf("cur_cmd axis %0d", k), rd, 32'h0);
        end

        encoder_steps(60);                         // Random walk on every axis
        check_counts();

        for (int k = 0; k < 8; k++) begin          // Preload and then step on
            cnt_model[k] = $urandom;
            write_reg(reg_addr(k + 1, `DQLA_OFF_ENC_LOAD), cnt_model[k], 1'b0);
        end
        encoder_steps(20);
        check_counts();

        single_update(1 + int'($urandom % 8), 16'($urandom));
        single_update(1 + int'($urandom % 8), 16'($urandom));

        // Second block lands while the first update is still shifting
        base = updates;
        write_block();
        push_expected();
        wait_busy(1'b1, "first block update start");
        write_block();
        check_value("dac_busy at second block", 32'(i_dqla_top.dac_busy), 32'h1);
        push_expected();
        wait_busy(1'b0, "first block update end");
        wait_busy(1'b1, "second block update start");
        wait_busy(1'b0, "second block update end");
        wait_frames();
        repeat (50) tick();
        check_value("block update count", 32'(updates - base), 32'd2);

        // Timestamp runs one count per cycle
        k_wait = 5 + int'($urandom % 40);
        read_reg(reg_addr(0, `DQLA_OFF_TIMESTAMP), t1);
        check_value("timestamp", timestamp, t1 + 32'd1);   // Port is one count ahead of the read
        repeat (k_wait) tick();
        check_value("timestamp delta", reg_rdata - t1, 32'(k_wait));
        read_reg(reg_addr(0, 4'd3), rd);
        check_value("unmapped read", rd, 32'h0);

        $display("Result: %0d checks, %0d mismatches, %0d other errors",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- source/dqla_top.sv
// DQLA top level: encoder array, command registers, DAC controller and readback
`timescale 1ns/1ns
`include "dqla_settings.svh"

module dqla_top (
    input  logic                          sysclk,
    input  logic                          arst_n,
    // Register bus
    input  dqla_pkg::reg_addr_t           reg_raddr,
    output dqla_pkg::reg_data_t           reg_rdata,
    input  dqla_pkg::reg_addr_t           reg_waddr,
    input  dqla_pkg::reg_data_t           reg_wdata,
    input  logic                          reg_wen,
    input  logic                          blk_wen,
    // Encoders, bit k-1 is axis k
    input  logic [`DQLA_NUM_AXES-1:0]     enc_a,
    input  logic [`DQLA_NUM_AXES-1:0]     enc_b,
    // DAC chains
    output logic                          dac_sclk,
    output logic [1:0]                    dac_mosi,
    output logic [1:0]                    dac_cs_n,
    output dqla_pkg::reg_data_t           timestamp
);
    import dqla_pkg::*;

    cur_cmd_t [`DQLA_NUM_AXES-1:0]    cur_cmd_flat;
    enc_count_t [`DQLA_NUM_AXES-1:0]  enc_count_flat;
    logic                             data_ready;    // Start request to DAC controller
    logic                             dac_busy;
    axis_sel_t                        wr_chan;
    logic                             wr_load;       // Preload write, any axis
    logic [`DQLA_NUM_AXES-1:0]        preload_wen;

    // --------------------------------------------------
    // Encoders
    // --------------------------------------------------
    assign wr_chan = reg_waddr[7:4];
    assign wr_load = reg_wen && (reg_waddr[15:12] == `DQLA_ADDR_MAIN) &&
                     (reg_waddr[3:0] == `DQLA_OFF_ENC_LOAD);

    for (genvar k = 0; k < `DQLA_NUM_AXES; k++) begin : g_enc
        assign preload_wen[k] = wr_load && (wr_chan == axis_sel_t'(k + 1));

        quad_encoder i_quad_encoder (
            .sysclk        (sysclk),
            .arst_n        (arst_n),
            .enc_a         (enc_a[k]),
            .enc_b         (enc_b[k]),
            .preload_wen   (preload_wen[k]),
            .preload_value (reg_wdata),
            .count         (enc_count_flat[k])
        );
    end

    // --------------------------------------------------
    // Commanded current and DACs
    // --------------------------------------------------
    motor_cmd_regs i_motor_cmd_regs (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .blk_wen      (blk_wen),
        .busy         (dac_busy),
        .cur_cmd_flat (cur_cmd_flat),
        .data_ready   (data_ready)
    );

    // Both chains share sclk and the start request
    dac_chain_ctrl i_dac_chain_ctrl (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .data_ready   (data_ready),
        .cur_cmd_flat (cur_cmd_flat),
        .busy         (dac_busy),
        .sclk         (dac_sclk),
        .mosi         (dac_mosi),
        .cs_n         (dac_cs_n)
    );

    // Read path and timestamp
    dqla_readback i_dqla_readback (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .reg_raddr      (reg_raddr),
        .cur_cmd_flat   (cur_cmd_flat),
        .enc_count_flat (enc_count_flat),
        .timestamp      (timestamp),
        .reg_rdata      (reg_rdata)
    );

endmodule

//--- source/dqla_readback.sv
// Free-running timestamp and registered read-data multiplexer
`timescale 1ns/1ns
`include "dqla_settings.svh"

module dqla_readback (
    input  logic                                       sysclk,
    input  logic                                       arst_n,
    input  dqla_pkg::reg_addr_t                        reg_raddr,
    input  dqla_pkg::cur_cmd_t [`DQLA_NUM_AXES-1:0]    cur_cmd_flat,
    input  dqla_pkg::enc_count_t [`DQLA_NUM_AXES-1:0]  enc_count_flat,
    output dqla_pkg::reg_data_t                        timestamp,
    output dqla_pkg::reg_data_t                        reg_rdata
);
    import dqla_pkg::*;

    localparam int AXIS_W = $clog2(`DQLA_NUM_AXES);

    axis_sel_t         rd_chan;
    logic [3:0]        rd_off;
    logic [AXIS_W-1:0] rd_axis;
    reg_data_t         rd_next;

    assign rd_chan = reg_raddr[7:4];
    assign rd_off  = reg_raddr[3:0];
    assign rd_axis = AXIS_W'(rd_chan - 4'd1);

    // Read select, zero for anything unmapped
    always_comb begin
        rd_next = '0;
        if (reg_raddr[15:12] == `DQLA_ADDR_MAIN) begin
            if (rd_chan == 4'd0) begin
                if (rd_off == `DQLA_OFF_TIMESTAMP)
                    rd_next = timestamp;
            end else if (rd_chan <= `DQLA_NUM_AXES) begin
                case (rd_off)
                    `DQLA_OFF_DAC_CTRL: rd_next = {16'd0, cur_cmd_flat[rd_axis]};
                    `DQLA_OFF_ENC_DATA: rd_next = enc_count_flat[rd_axis];
                    default:            rd_next = '0;    // Preload reads back 0
                endcase
            end
        end
    end

    // --------------------------------------------------
    // Timestamp and read register, one cycle latency
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            timestamp <= '0;
            reg_rdata <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
            reg_rdata <= rd_next;
        end
    end

endmodule

//--- source/dac_chain_ctrl.sv
// Two-chain DAC serialiser: word latch, sclk divider and frame shift FSM
`timescale 1ns/1ns
`include "dqla_settings.svh"

module dac_chain_ctrl (
    input  logic                                     sysclk,
    input  logic                                     arst_n,
    input  logic                                     data_ready,
    input  dqla_pkg::cur_cmd_t [`DQLA_NUM_AXES-1:0]  cur_cmd_flat,
    output logic                                     busy,
    output logic                                     sclk,
    output logic [1:0]                               mosi,     // [0] chain 1, [1] chain 2
    output logic [1:0]                               cs_n
);
    import dqla_pkg::*;

    localparam int CHAIN_AXES = `DQLA_NUM_AXES / 2;
    localparam int FRAME_BITS = `DQLA_DAC_FRAME_BITS;
    localparam int GAP_TICKS  = 4 * `DQLA_SCLK_DIV;    // Two sclk periods
    localparam int FRAME_W    = $clog2(CHAIN_AXES);
    localparam int BIT_W      = $clog2(FRAME_BITS);
    localparam int TICK_W     = $clog2(GAP_TICKS);

    dac_state_t                      state;
    cur_cmd_t [1:0][CHAIN_AXES-1:0]  words;       // Snapshot taken at update start
    logic [FRAME_BITS-1:0]           sr [2];      // One shifter per chain
    logic [FRAME_W-1:0]              frame_idx;   // DAC address within chain
    logic [BIT_W-1:0]                bit_cnt;
    logic [TICK_W-1:0]               tick_cnt;

    // Command, address, data, MSB first
    function automatic logic [FRAME_BITS-1:0] make_frame(input logic [3:0] addr,
                                                         input cur_cmd_t value);
        return {`DQLA_DAC_CMD, addr, value};
    endfunction

    assign mosi = {sr[1][FRAME_BITS-1], sr[0][FRAME_BITS-1]};

    // Both chains latch together so they stay in step
    always_ff @(posedge sysclk) begin
        if (state == dac_idle && data_ready) begin
            for (int i = 0; i < CHAIN_AXES; i++) begin
                words[0][i] <= cur_cmd_flat[i];
                words[1][i] <= cur_cmd_flat[i + CHAIN_AXES];
            end
        end
    end

    // --------------------------------------------------
    // Frame sequencer
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= dac_idle;
            busy      <= 1'b0;
            sclk      <= 1'b0;
            cs_n      <= 2'b11;
            frame_idx <= '0;
            bit_cnt   <= '0;
            tick_cnt  <= '0;
            sr[0]     <= '0;
            sr[1]     <= '0;
        end else begin
            case (state)
                dac_idle: if (data_ready) begin
                    busy      <= 1'b1;
                    frame_idx <= '0;
                    state     <= dac_load;
                end
                dac_load: begin
                    sr[0]    <= make_frame(4'(frame_idx), words[0][frame_idx]);
                    sr[1]    <= make_frame(4'(frame_idx), words[1][frame_idx]);
                    cs_n     <= 2'b00;         // First bit valid with cs_n
                    bit_cnt  <= '0;
                    tick_cnt <= '0;
                    state    <= dac_shift;
                end
                dac_shift: if (tick_cnt == TICK_W'(`DQLA_SCLK_DIV - 1)) begin
                    tick_cnt <= '0;
                    sclk     <= ~sclk;
                    if (sclk) begin            // Falling edge, next bit out
                        if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                            cs_n  <= 2'b11;
                            state <= dac_gap;
                        end else begin
                            sr[0]   <= sr[0] << 1;
                            sr[1]   <= sr[1] << 1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
                dac_gap: if (tick_cnt == TICK_W'(GAP_TICKS - 1)) begin
                    tick_cnt <= '0;
                    if (frame_idx == FRAME_W'(CHAIN_AXES - 1)) begin
                        busy  <= 1'b0;         // All four DACs written
                        state <= dac_idle;
                    end else begin
                        frame_idx <= frame_idx + 1'b1;
                        state     <= dac_load;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
                default: state <= dac_idle;
            endcase
        end
    end

    // No chip select may be active outside an update
    a_cs_idle: assert property (@(posedge sysclk) disable iff (!arst_n)
        !busy |-> cs_n == 2'b11);

endmodule

//--- source/motor_cmd_regs.sv
// Per-axis commanded-current registers and the DAC update request/updated handshake
`timescale 1ns/1ns
`include "dqla_settings.svh"

module motor_cmd_regs (
    input  logic                                     sysclk,
    input  logic                                     arst_n,
    input  dqla_pkg::reg_addr_t                      reg_waddr,
    input  dqla_pkg::reg_data_t                      reg_wdata,
    input  logic                                     reg_wen,
    input  logic                                     blk_wen,
    input  logic                                     busy,
    output dqla_pkg::cur_cmd_t [`DQLA_NUM_AXES-1:0]  cur_cmd_flat,
    output logic                                     data_ready
);
    import dqla_pkg::*;

    localparam int AXIS_W = $clog2(`DQLA_NUM_AXES);

    axis_sel_t   wr_chan;
    logic [AXIS_W-1:0] wr_axis;
    logic        dac_addr;      // Write address hits a DAC register
    logic        blk_dac;       // DAC written earlier in this block
    logic        trigger;
    logic        cmd_req;       // Update pending behind a busy chain
    logic        cmd_updated;   // Start request to the DAC controller

    assign wr_chan = reg_waddr[7:4];
    assign wr_axis = AXIS_W'(wr_chan - 4'd1);   // Channel 1 is index 0

    // Axis channels only, channel 0 holds board registers
    assign dac_addr = (reg_waddr[15:12] == `DQLA_ADDR_MAIN) &&
                      (reg_waddr[3:0] == `DQLA_OFF_DAC_CTRL) &&
                      (wr_chan != 4'd0) && (wr_chan <= `DQLA_NUM_AXES);

    // --------------------------------------------------
    // Command storage
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            cur_cmd_flat <= '0;
        else if (reg_wen && dac_addr)
            cur_cmd_flat[wr_axis] <= reg_wdata[15:0];   // Bit 31 is the update flag
    end

    // Block flag, cleared by the block strobe that ends the block
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            blk_dac <= 1'b0;
        else if (blk_wen)
            blk_dac <= 1'b0;
        else if (reg_wen && dac_addr)
            blk_dac <= 1'b1;
    end

    // Block update, or a single quadlet write with bit 31 set
    assign trigger = blk_wen && dac_addr && (blk_dac || (reg_wen && reg_wdata[31]));

    // --------------------------------------------------
    // Request/updated handshake
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_req     <= 1'b0;
            cmd_updated <= 1'b0;
        end else if (trigger) begin
            cmd_req     <= busy;      // Merges into the one pending update
            cmd_updated <= ~busy;
        end else if (cmd_req && !busy) begin
            cmd_req     <= 1'b0;      // Chain free again, start pending update
            cmd_updated <= 1'b1;
        end else if (cmd_updated && busy) begin
            cmd_updated <= 1'b0;      // Controller has taken it
        end
    end

    assign data_ready = cmd_updated;

    // A pending request and a live start would mean two updates in flight
    a_one_pending: assert property (@(posedge sysclk) disable iff (!arst_n)
        !(cmd_req && cmd_updated));

endmodule

//--- source/quad_encoder.sv
// One-axis quadrature encoder: input synchronisers, 4x decoder and preloadable counter
`timescale 1ns/1ns

module quad_encoder (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  logic                 enc_a,
    input  logic                 enc_b,
    input  logic                 preload_wen,
    input  dqla_pkg::reg_data_t  preload_value,
    output dqla_pkg::enc_count_t count
);

    logic [1:0] a_sync;   // [1] is the synchronised value
    logic [1:0] b_sync;
    logic       a_prev;   // Last decoded state
    logic       b_prev;
    logic       a_chg;
    logic       b_chg;
    logic       step;     // Exactly one input moved
    logic       count_up;

    // --------------------------------------------------
    // Synchronisers, two flops per input
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            a_sync <= '0;
            b_sync <= '0;
            a_prev <= 1'b0;
            b_prev <= 1'b0;
        end else begin
            a_sync <= {a_sync[0], enc_a};
            b_sync <= {b_sync[0], enc_b};
            a_prev <= a_sync[1];
            b_prev <= b_sync[1];
        end
    end

    // Gray code decode
    assign a_chg    = a_sync[1] ^ a_prev;
    assign b_chg    = b_sync[1] ^ b_prev;
    assign step     = a_chg ^ b_chg;         // Both moving is illegal, no count
    assign count_up = a_sync[1] ^ b_prev;    // 1 when a leads b

    // --------------------------------------------------
    // Position counter
    // --------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (preload_wen) begin
            count <= preload_value;          // Host write wins over a step
        end else if (step) begin
            if (count_up)
                count <= count + 1'b1;
            else
                count <= count - 1'b1;
        end
    end

    // A skipped Gray state means the input sampling is too slow for the encoder
    a_no_double_edge: assert property (@(posedge sysclk) disable iff (!arst_n)
        !(a_chg && b_chg));

endmodule

//--- source/dqla_pkg.sv
// Shared bus, command and encoder typedefs plus the DAC controller state enum
package dqla_pkg;

    typedef logic [15:0] reg_addr_t;   // [15:12] space, [7:4] channel, [3:0] offset
    typedef logic [31:0] reg_data_t;
    typedef logic [15:0] cur_cmd_t;    // Commanded current, DAC code
    typedef logic [31:0] enc_count_t;  // Signed position, two's complement
    typedef logic [3:0]  axis_sel_t;   // 0 = board regs, 1..8 = axes

    // DAC chain sequencer
    typedef enum logic [1:0] {
        dac_idle,   // Waiting for data_ready
        dac_load,   // Build next frame, drop cs_n
        dac_shift,  // Clock out frame bits
        dac_gap     // cs_n high between frames
    } dac_state_t;

endpackage

//--- source/dqla_settings.svh
// Address map, axis counts, DAC frame layout and sclk divide for the DQLA controller
`ifndef DQLA_SETTINGS_SVH
`define DQLA_SETTINGS_SVH

// Board layout
`define DQLA_NUM_AXES        8        // Two chains of four axes each

// --------------------------------------------------
// Register bus address map
// --------------------------------------------------
`define DQLA_ADDR_MAIN       4'd0     // Space in addr[15:12]; other spaces ignored
`define DQLA_OFF_TIMESTAMP   4'd10    // Channel 0 only
`define DQLA_OFF_DAC_CTRL    4'd1     // Commanded current, per axis
`define DQLA_OFF_ENC_LOAD    4'd4     // Encoder preload (write only)
`define DQLA_OFF_ENC_DATA    4'd5     // Encoder count

// --------------------------------------------------
// DAC serial chains
// --------------------------------------------------
`define DQLA_DAC_CMD         4'b0011  // Write and update
`define DQLA_DAC_FRAME_BITS  24       // Command, address, 16-bit data
`define DQLA_SCLK_DIV        2        // sysclk cycles per sclk half period

`endif
